/* exSlice_stimulus.txt */
# columns, all hex: instr pcPlus4 writeEnable writeReg writeData nextPc
# writeReg and writeData are only compared when writeEnable is 1
20010005 00400004 1 01 00000005 00400004
2022fffd 00400008 1 02 00000002 00400008
34038001 0040000c 1 03 00008001 0040000c
3c041234 00400010 1 04 12340000 00400010
00222820 00400014 1 05 00000007 00400014
00413022 00400018 1 06 fffffffd 00400018
00653824 0040001c 1 07 00000001 0040001c
00834025 00400020 1 08 12348001 00400020
00c1482a 00400024 1 09 00000001 00400024
0026502a 00400028 1 0a 00000000 00400028
310bffff 0040002c 1 0b 00008001 0040002c
28ccfffe 00400030 1 0c 00000001 00400030
20200010 00400034 0 00 00000000 00400034
00006820 00400038 1 0d 00000000 00400038
00017020 0040003c 1 0e 00000005 0040003c
10250004 00400040 0 00 00000000 00400040
10e9fffe 00400044 0 00 00000000 0040003c
14220010 00400048 0 00 00000000 00400088
15270010 0040004c 0 00 00000000 0040004c
08100040 00400050 0 00 00000000 00400100
0bffffff a0000010 0 00 00000000 affffffc
200f0007 a0000014 1 0f 00000007 a0000014
11e50003 a0000018 0 00 00000000 a0000024

/* filelist.f */
+incdir+.
isaPkg.sv
pipePkg.sv
stageReg.sv
decodeStage.sv
aluUnit.sv
nextPcUnit.sv
commitUnit.sv
exSlice.sv
exSlice_properties.sv
tbExSlice.sv

/* Makefile */
# Verilator build and run of the execute slice testbench

BUILD = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tbExSlice -Mdir $(BUILD) -o simExSlice

# the log decides pass or fail
run: compile
	./$(BUILD)/simExSlice | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* tbExSlice.sv */
//########################################
// testbench for the decode-and-execute slice
// file-driven issue with random gaps, commit checks
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module tbExSlice;

	// one expected commit, tagged with the cycle of its issue
	typedef struct packed {
		logic                       we;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0]     data;
		logic [`DATA_WIDTH-1:0]     nextPc;
		logic [31:0]                issueCycle;
	} expectT;

	logic                       clk;
	logic                       rstN;
	logic                       issue;
	logic [`INSTR_WIDTH-1:0]    instr;
	logic [`DATA_WIDTH-1:0]     pcPlus4;
	logic                       done;
	logic                       writeEnable;
	logic [`REG_ADDR_WIDTH-1:0] writeReg;
	logic [`DATA_WIDTH-1:0]     writeData;
	logic [`DATA_WIDTH-1:0]     nextPc;

	expectT      expQ[$];
	logic [31:0] cycleCount = '0;
	logic [31:0] rngState;

	exSlice dut (
		.clk        (clk),
		.rstN       (rstN),
		.issue      (issue),
		.instr      (instr),
		.pcPlus4    (pcPlus4),
		.done       (done),
		.writeEnable(writeEnable),
		.writeReg   (writeReg),
		.writeData  (writeData),
		.nextPc     (nextPc)
	);

	// port names resolve inside exSlice
	bind exSlice exSliceProperties props (
		.clk        (clk),
		.rstN       (rstN),
		.issue      (issue),
		.done       (done),
		.writeEnable(writeEnable),
		.writeReg   (writeReg)
	);

	// 10 ns period
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// report the reason, then stop the run
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else failRun($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	// xorshift32 step
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// outputs sampled on the rising edge still hold the cycle that just ended
	always @(posedge clk) begin : commitMonitor
		expectT front;
		cycleCount <= cycleCount + 1;
		if (rstN) begin
			assert (!(writeEnable && (writeReg == '0)))
			else failRun("write enable raised for register zero");
			if (done) begin
				assert (expQ.size() > 0)
				else failRun("done pulse seen with no instruction outstanding");
				front = expQ.pop_front();
				// latency counted in cycles, issue cycle to done cycle
				checkValue("done cycle", front.issueCycle + 2, cycleCount - 1);
				checkValue("writeEnable", 32'(front.we), 32'(writeEnable));
				// reg and data only mean something on a write
				if (front.we) begin
					checkValue("writeReg", 32'(front.dest), 32'(writeReg));
					checkValue("writeData", front.data, writeData);
				end
				checkValue("nextPc", front.nextPc, nextPc);
			end
		end
	end

	initial begin : issueDriver
		int          fd;
		int          fields;
		int          gap;
		int          issued;
		int          waited;
		string       line;
		logic [31:0] wordIn;
		logic [31:0] pcIn;
		logic [31:0] weIn;
		logic [31:0] regIn;
		logic [31:0] dataIn;
		logic [31:0] nextPcIn;
		expectT      entry;

		rstN    <= 1'b0;
		issue   <= 1'b0;
		instr   <= '0;
		pcPlus4 <= '0;
		rngState = 32'h4d6e_e051;
		issued   = 0;

		repeat (5) @(posedge clk);
		rstN <= 1'b1;

		fd = $fopen("exSlice_stimulus.txt", "r");
		assert (fd != 0) else failRun("could not open the stimulus file");

		while ($fgets(line, fd) != 0) begin
			fields = $sscanf(line, "%h %h %h %h %h %h",
				wordIn, pcIn, weIn, regIn, dataIn, nextPcIn);
			// comment lines do not parse as six fields
			if (fields == 6) begin
				// 0 to 2 idle cycles, back-to-back pairs go through the bypass
				rngState = xorshift(rngState);
				gap      = int'(rngState % 3);
				repeat (gap) begin
					@(posedge clk);
					issue <= 1'b0;
				end
				@(posedge clk);
				issue   <= 1'b1;
				instr   <= wordIn;
				pcPlus4 <= pcIn;
				entry.we         = weIn[0];
				entry.dest       = regIn[`REG_ADDR_WIDTH-1:0];
				entry.data       = dataIn;
				entry.nextPc     = nextPcIn;
				entry.issueCycle = cycleCount;
				expQ.push_back(entry);
				issued++;
			end
		end
		$fclose(fd);
		@(posedge clk);
		issue <= 1'b0;
		assert (issued > 0) else failRun("the stimulus file holds no instruction");

		// drain, polled on the falling edge
		waited = 0;
		while ((expQ.size() != 0) && (waited < 10)) begin
			@(negedge clk);
			waited++;
		end
		assert (expQ.size() == 0)
		else failRun("timed out waiting for outstanding done pulses");

		// quiet cycles so a stray done still reaches the monitor
		repeat (4) @(posedge clk);
		$display("NO ERRORS");
		$finish;
	end

endmodule

/* exSlice_properties.sv */
//########################################
// execute slice checks
// strobe timing and the register-zero rule
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module exSliceProperties (
	input logic                       clk,
	input logic                       rstN,
	input logic                       issue,
	input logic                       done,
	input logic                       writeEnable,
	input logic [`REG_ADDR_WIDTH-1:0] writeReg
);

	// fixed latency of two cycles, seen from both ends
	issueToDone: assert property (@(posedge clk) disable iff (!rstN) issue |-> ##2 done)
		else $error("done missing two cycles after issue");

	doneFromIssue: assert property (@(posedge clk) disable iff (!rstN) done |-> $past(issue, 2))
		else $error("done without an issue two cycles earlier");

	// pipeline leaves reset empty
	doneAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !done)
		else $error("done high in the cycle after reset");

	// r0 targets are dropped at commit
	noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
		writeEnable |-> (writeReg != '0))
		else $error("write enable raised for register zero");

endmodule

/* exSlice.sv */
//########################################
// decode-and-execute slice top
// decode, ALU, next-pc and commit
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module exSlice (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       issue,
	input  logic [`INSTR_WIDTH-1:0]    instr,
	input  logic [`DATA_WIDTH-1:0]     pcPlus4,
	output logic                       done,
	output logic                       writeEnable,
	output logic [`REG_ADDR_WIDTH-1:0] writeReg,
	output logic [`DATA_WIDTH-1:0]     writeData,
	output logic [`DATA_WIDTH-1:0]     nextPc
);

	// execute stage
	logic                       exValid;
	pipePkg::decodedInstrT      exInstr;
	logic [`DATA_WIDTH-1:0]     aluResult;
	logic [`DATA_WIDTH-1:0]     exNextPc;

	// bypass from execute
	logic                       fwdValid;
	logic [`REG_ADDR_WIDTH-1:0] fwdReg;
	logic [`DATA_WIDTH-1:0]     fwdData;

	// rf write port is the committed record itself
	decodeStage decode (
		.clk     (clk),
		.rstN    (rstN),
		.issue   (issue),
		.instr   (instr),
		.pcPlus4 (pcPlus4),
		.fwdValid(fwdValid),
		.fwdReg  (fwdReg),
		.fwdData (fwdData),
		.rfWrite (writeEnable),
		.rfReg   (writeReg),
		.rfData  (writeData),
		.exValid (exValid),
		.exInstr (exInstr)
	);

	aluUnit alu (
		.exInstr  (exInstr),
		.aluResult(aluResult)
	);

	nextPcUnit nextPcCalc (
		.exInstr(exInstr),
		.nextPc (exNextPc)
	);

	commitUnit commit (
		.clk        (clk),
		.rstN       (rstN),
		.exValid    (exValid),
		.exInstr    (exInstr),
		.aluResult  (aluResult),
		.nextPc     (exNextPc),
		.fwdValid   (fwdValid),
		.fwdReg     (fwdReg),
		.fwdData    (fwdData),
		.done       (done),
		.writeEnable(writeEnable),
		.writeReg   (writeReg),
		.writeData  (writeData),
		.nextPcOut  (nextPc)
	);

endmodule

/* commitUnit.sv */
//########################################
// commit stage
// builds, registers and reports the commit record
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module commitUnit (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       exValid,
	input  pipePkg::decodedInstrT      exInstr,
	input  logic [`DATA_WIDTH-1:0]     aluResult,
	input  logic [`DATA_WIDTH-1:0]     nextPc,
	output logic                       fwdValid,
	output logic [`REG_ADDR_WIDTH-1:0] fwdReg,
	output logic [`DATA_WIDTH-1:0]     fwdData,
	output logic                       done,
	output logic                       writeEnable,
	output logic [`REG_ADDR_WIDTH-1:0] writeReg,
	output logic [`DATA_WIDTH-1:0]     writeData,
	output logic [`DATA_WIDTH-1:0]     nextPcOut
);

	pipePkg::commitRecordT exRecord;
	pipePkg::commitRecordT committed;

	// single point of write decision
	// r0 targets are dropped here
	assign exRecord.writeEnable = exValid && exInstr.writeEnable && (exInstr.destReg != '0);
	assign exRecord.destReg     = exInstr.destReg;
	assign exRecord.data        = aluResult;
	assign exRecord.nextPc      = nextPc;

	// bypass to decode, straight from execute
	assign fwdValid = exRecord.writeEnable;
	assign fwdReg   = exRecord.destReg;
	assign fwdData  = exRecord.data;

	stageReg #(
		.payloadT(pipePkg::commitRecordT)
	) commitReg (
		.clk    (clk),
		.rstN   (rstN),
		.load   (exValid),
		.dataIn (exRecord),
		.valid  (done),
		.dataOut(committed)
	);

	// write enable only counts during done, it also drives the rf write port
	assign writeEnable = done && committed.writeEnable;
	assign writeReg    = committed.destReg;
	assign writeData   = committed.data;
	assign nextPcOut   = committed.nextPc;

endmodule

/* nextPcUnit.sv */
//########################################
// execute next-pc logic
// branch/jump targets and taken decision
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module nextPcUnit (
	input  pipePkg::decodedInstrT   exInstr,
	output logic [`DATA_WIDTH-1:0]  nextPc
);

	logic [`DATA_WIDTH-1:0] branchTarget;
	logic [`DATA_WIDTH-1:0] jumpTarget;
	logic                   operandsEqual;
	logic                   branchTaken;

	// word offset relative to pc+4
	assign branchTarget = exInstr.pcPlus4 + (exInstr.imm << 2);

	// region bits from pc+4, index, word aligned
	assign jumpTarget = {exInstr.pcPlus4[`DATA_WIDTH-1 -: 4], exInstr.jumpIndex, 2'b00};

	// operands already carry forwarded values
	assign operandsEqual = (exInstr.opA == exInstr.opB);

	assign branchTaken = (exInstr.isBeq && operandsEqual) ||
		(exInstr.isBne && !operandsEqual);

	// jump wins, then taken branch, else fall through
	always_comb begin
		if (exInstr.isJump) begin
			nextPc = jumpTarget;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = exInstr.pcPlus4;
		end
	end

endmodule

/* aluUnit.sv */
//########################################
// execute ALU
// source B select and arithmetic/logic ops
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module aluUnit (
	input  pipePkg::decodedInstrT   exInstr,
	output logic [`DATA_WIDTH-1:0]  aluResult
);

	logic [`DATA_WIDTH-1:0] srcA;
	logic [`DATA_WIDTH-1:0] srcB;
	logic                   logicOp;

	assign srcA = exInstr.opA;

	// andi and ori take the immediate zero-extended
	assign logicOp = (exInstr.aluOp == isaPkg::aluAnd) || (exInstr.aluOp == isaPkg::aluOr);

	// second source
	always_comb begin
		if (!exInstr.useImm) begin
			srcB = exInstr.opB;
		end else if (logicOp) begin
			srcB = {{(`DATA_WIDTH-16){1'b0}}, exInstr.imm[15:0]};
		end else begin
			srcB = exInstr.imm;
		end
	end

	// operation select
	always_comb begin
		case (exInstr.aluOp)
			isaPkg::aluAnd: aluResult = srcA & srcB;
			isaPkg::aluOr:  aluResult = srcA | srcB;
			isaPkg::aluAdd: aluResult = srcA + srcB;
			isaPkg::aluSub: aluResult = srcA - srcB;
			// signed compare, result is 0 or 1
			isaPkg::aluSlt: begin
				aluResult = ($signed(srcA) < $signed(srcB)) ? `DATA_WIDTH'(1) : '0;
			end
			// lui places the 16-bit field in the upper half
			isaPkg::aluLui: aluResult = {exInstr.imm[15:0], {(`DATA_WIDTH-16){1'b0}}};
			default:        aluResult = '0;
		endcase
	end

endmodule

/* decodeStage.sv */
//########################################
// decode stage
// field decode, register file, forward muxes
//########################################

`timescale 1ns/1ps
`include "exSlice_config.svh"

module decodeStage (
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       issue,
	input  logic [`INSTR_WIDTH-1:0]    instr,
	input  logic [`DATA_WIDTH-1:0]     pcPlus4,
	input  logic                       fwdValid,
	input  logic [`REG_ADDR_WIDTH-1:0] fwdReg,
	input  logic [`DATA_WIDTH-1:0]     fwdData,
	input  logic                       rfWrite,
	input  logic [`REG_ADDR_WIDTH-1:0] rfReg,
	input  logic [`DATA_WIDTH-1:0]     rfData,
	output logic                       exValid,
	output pipePkg::decodedInstrT      exInstr
);

	logic [5:0]                  opcode;
	logic [5:0]                  funct;
	logic [`REG_ADDR_WIDTH-1:0]  rs;
	logic [`REG_ADDR_WIDTH-1:0]  rt;
	logic [`REG_ADDR_WIDTH-1:0]  rd;
	logic [`DATA_WIDTH-1:0]      regFile [`REG_COUNT];
	pipePkg::decodedInstrT       decoded;

	// instruction fields
	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign funct  = instr[5:0];

	// register file, all zero out of reset
	// entry 0 is never written
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (rfWrite && (rfReg != '0)) begin
			regFile[rfReg] <= rfData;
		end
	end

	// operand read priority
	// r0, execute-stage bypass, commit write port, array
	// commit write lands on the closing edge and is passed through here
	always_comb begin
		if (rs == '0) decoded.opA = '0;
		else if (fwdValid && (fwdReg == rs)) decoded.opA = fwdData;
		else if (rfWrite && (rfReg == rs)) decoded.opA = rfData;
		else decoded.opA = regFile[rs];

		if (rt == '0) decoded.opB = '0;
		else if (fwdValid && (fwdReg == rt)) decoded.opB = fwdData;
		else if (rfWrite && (rfReg == rt)) decoded.opB = rfData;
		else decoded.opB = regFile[rt];
	end

	// passthrough fields
	assign decoded.imm       = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
	assign decoded.jumpIndex = instr[25:0];
	assign decoded.pcPlus4   = pcPlus4;

	// control decode
	// unknown opcode or funct ends up as a no-write add
	always_comb begin
		decoded.aluOp       = isaPkg::aluAdd;
		decoded.useImm      = 1'b0;
		decoded.isBeq       = 1'b0;
		decoded.isBne       = 1'b0;
		decoded.isJump      = 1'b0;
		decoded.writeEnable = 1'b0;
		decoded.destReg     = rt;
		case (opcode)
			isaPkg::opRType: begin
				decoded.destReg     = rd;
				decoded.writeEnable = 1'b1;
				case (funct)
					isaPkg::functAdd: decoded.aluOp = isaPkg::aluAdd;
					isaPkg::functSub: decoded.aluOp = isaPkg::aluSub;
					isaPkg::functAnd: decoded.aluOp = isaPkg::aluAnd;
					isaPkg::functOr:  decoded.aluOp = isaPkg::aluOr;
					isaPkg::functSlt: decoded.aluOp = isaPkg::aluSlt;
					default:          decoded.writeEnable = 1'b0;
				endcase
			end
			// I-type writes rt
			isaPkg::opAddi: begin
				decoded.aluOp       = isaPkg::aluAdd;
				decoded.useImm      = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			isaPkg::opAndi: begin
				decoded.aluOp       = isaPkg::aluAnd;
				decoded.useImm      = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			isaPkg::opOri: begin
				decoded.aluOp       = isaPkg::aluOr;
				decoded.useImm      = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			isaPkg::opSlti: begin
				decoded.aluOp       = isaPkg::aluSlt;
				decoded.useImm      = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			isaPkg::opLui: begin
				decoded.aluOp       = isaPkg::aluLui;
				decoded.useImm      = 1'b1;
				decoded.writeEnable = 1'b1;
			end
			// control flow, no register write
			isaPkg::opBeq: decoded.isBeq  = 1'b1;
			isaPkg::opBne: decoded.isBne  = 1'b1;
			isaPkg::opJ:   decoded.isJump = 1'b1;
			default: decoded.writeEnable = 1'b0;
		endcase
	end

	// decode-to-execute register
	stageReg #(
		.payloadT(pipePkg::decodedInstrT)
	) decodeReg (
		.clk    (clk),
		.rstN   (rstN),
		.load   (issue),
		.dataIn (decoded),
		.valid  (exValid),
		.dataOut(exInstr)
	);

endmodule

/* stageReg.sv */
//########################################
// pipeline stage register
// captures a payload and flags it for one cycle
//########################################

`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    load,
	input  payloadT dataIn,
	output logic    valid,
	output payloadT dataOut
);

	// strobe follows load by one cycle, never held
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			valid <= 1'b0;
		end else begin
			valid <= load;
		end
	end

	// payload only, keeps last value between loads
	always_ff @(posedge clk) begin
		if (load) begin
			dataOut <= dataIn;
		end
	end

endmodule

/* pipePkg.sv */
//########################################
// pipeline record types
// decode-to-execute and commit payloads
//########################################

`include "exSlice_config.svh"

package pipePkg;

	// one decoded instruction, as held in execute
	typedef struct packed {
		isaPkg::aluOpT                aluOp;
		logic                         useImm;
		logic                         isBeq;
		logic                         isBne;
		logic                         isJump;
		// decode-side intent, commit makes the final call
		logic                         writeEnable;
		logic [`REG_ADDR_WIDTH-1:0]   destReg;
		// operands after forwarding
		logic [`DATA_WIDTH-1:0]       opA;
		logic [`DATA_WIDTH-1:0]       opB;
		// sign-extended 16-bit immediate
		logic [`DATA_WIDTH-1:0]       imm;
		logic [25:0]                  jumpIndex;
		logic [`DATA_WIDTH-1:0]       pcPlus4;
	} decodedInstrT;

	// one finished instruction
	typedef struct packed {
		logic                         writeEnable;
		logic [`REG_ADDR_WIDTH-1:0]   destReg;
		logic [`DATA_WIDTH-1:0]       data;
		logic [`DATA_WIDTH-1:0]       nextPc;
	} commitRecordT;

endpackage

/* isaPkg.sv */
//########################################
// instruction set encodings
// opcodes, funct codes and ALU operations
//########################################

package isaPkg;

	// primary opcode field, instr[31:26]
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opSlti  = 6'h0a;
	localparam logic [5:0] opAndi  = 6'h0c;
	localparam logic [5:0] opOri   = 6'h0d;
	localparam logic [5:0] opLui   = 6'h0f;

	// funct field for R-type, instr[5:0]
	localparam logic [5:0] functAdd = 6'h20;
	localparam logic [5:0] functSub = 6'h22;
	localparam logic [5:0] functAnd = 6'h24;
	localparam logic [5:0] functOr  = 6'h25;
	localparam logic [5:0] functSlt = 6'h2a;

	// ALU control encoding
	// bit 2 marks the subtracting operations (sub, slt)
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluLui = 3'b011,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluOpT;

endpackage

/* exSlice_config.svh */
//########################################
// execute slice configuration
// widths of registers, pc and instruction words
//########################################

`ifndef EXSLICE_CONFIG_SVH
`define EXSLICE_CONFIG_SVH

// register and pc width
`define DATA_WIDTH 32

// register file depth and index width
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// fetched instruction word
`define INSTR_WIDTH 32

`endif
